// File: files.f
design/cursor_pkg.sv
design/cursor_cfg_regs.sv
design/cursor_outline_fsm.sv
design/cursor_position.sv
design/blink_timer.sv
design/pixel_buffer.sv
design/cursor_palette_top.sv
tb/cursor_palette_tb.sv

// File: Bender.yml
package:
  name: cursor_palette

sources:
  - files:
      - design/cursor_pkg.sv
      - design/cursor_cfg_regs.sv
      - design/cursor_outline_fsm.sv
      - design/cursor_position.sv
      - design/blink_timer.sv
      - design/pixel_buffer.sv
      - design/cursor_palette_top.sv
  - target: test
    files:
      - tb/cursor_palette_tb.sv

// File: tb/cursor_palette_tb.sv
`timescale 1ns/1ps

module cursor_palette_tb
  import cursor_pkg::*;
();

  localparam int clk_period   = 8;
  localparam int drive_delay  = 1;
  localparam int reset_cycles = 5;
  localparam int pass_cycles  = 36;
  localparam int pass_writes  = 4 * side_len;
  localparam int n_fixed      = 4;
  localparam int n_runs       = 8;
  localparam int restart_wait = 12; // Lands inside the white pass.
  localparam int row_slack    = 20 + 6 + restart_wait + 2 * buf_words + 8;

  typedef struct packed {
    logic [coord_w-1:0] org_x;
    logic [coord_w-1:0] org_y;
    logic [hold_w-1:0]  white_hold;
    logic [hold_w-1:0]  black_hold;
    logic               restart;
  } run_row_t;

  logic               clk;
  logic               rst;
  logic               start;
  logic               cfg_we;
  cfg_addr_e          cfg_addr;
  logic [15:0]        cfg_wdata;
  logic [coord_w-1:0] rd_x;
  logic [coord_w-1:0] rd_y;
  logic               busy;
  logic               done;
  pix_wr_t            pix_wr;
  logic [pix_w-1:0]   rd_data;

  run_row_t           runs [n_runs];
  logic [pix_w-1:0]   model [buf_words];
  logic               written [buf_words];
  logic [7:0]         wr_pos_q [$]; // {y, x} of each write.
  logic [pix_w-1:0]   wr_data_q [$];
  int                 wr_cycle_q [$];
  int                 cycle_count;
  int                 timeout_limit;
  int                 done_count;
  int                 done_cycle;
  int                 start_cycle;
  logic               started;
  logic [31:0]        rng_state;

  cursor_palette_top cursor_palette_top_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .rd_x      (rd_x),
    .rd_y      (rd_y),
    .busy      (busy),
    .done      (done),
    .pix_wr    (pix_wr),
    .rd_data   (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Pixel i of a pass walks right, down, left, then up around the origin.
  function automatic logic [7:0] outline_pos(input logic [coord_w-1:0] x0,
                                              input logic [coord_w-1:0] y0, input int i);
    int side;
    int k;
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    side = (i % pass_writes) / side_len;
    k    = i % side_len;
    case (side)
      0: begin
        x = coord_w'(x0 + k);
        y = y0;
      end
      1: begin
        x = coord_w'(x0 + side_len);
        y = coord_w'(y0 + k);
      end
      2: begin
        x = coord_w'(x0 + side_len - k);
        y = coord_w'(y0 + side_len);
      end
      default: begin
        x = x0;
        y = coord_w'(y0 + side_len - k);
      end
    endcase
    return {y, x};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Mismatch at %0t: %s = %0h, expected %0h", $time, name, got, expected);
      $display("TEST FAILED");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #drive_delay;
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: the runs did not finish within %0d cycles", timeout_limit);
      $display("TEST FAILED");
      $fatal(1, "simulation timeout");
    end
  end

  // Samples mid-cycle and mirrors every write into the model.
  always @(negedge clk) begin
    if (!rst) begin
      if (!started) begin
        check_value("pix_wr.en", pix_wr.en, 1'b0);
        check_value("busy", busy, 1'b0);
        check_value("done", done, 1'b0);
      end
      if (pix_wr.en) begin
        wr_pos_q.push_back({pix_wr.y, pix_wr.x});
        wr_data_q.push_back(pix_wr.data);
        wr_cycle_q.push_back(cycle_count);
        model[{pix_wr.y, pix_wr.x}]   = pix_wr.data;
        written[{pix_wr.y, pix_wr.x}] = 1'b1;
      end
      if (done) begin
        done_count++;
        done_cycle = cycle_count;
      end
    end
  end

  task automatic build_table();
    int i;
    runs[0] = '{4'd0, 4'd0, 16'd1, 16'd1, 1'b0};
    runs[1] = '{4'd11, 4'd11, 16'd5, 16'd3, 1'b1};
    runs[2] = '{4'd3, 4'd7, 16'd20, 16'd2, 1'b0};
    runs[3] = '{4'd6, 4'd4, 16'd2, 16'd9, 1'b1}; // Overlaps run 2.
    for (i = n_fixed; i < n_runs; i++) begin
      rng_state = xorshift32(rng_state);
      runs[i].org_x      = coord_w'(rng_state % 12);
      runs[i].org_y      = coord_w'((rng_state >> 8) % 12);
      runs[i].white_hold = hold_w'(1 + ((rng_state >> 12) % 32));
      runs[i].black_hold = hold_w'(1 + ((rng_state >> 20) % 32));
      runs[i].restart    = rng_state[31];
    end
  endtask

  task automatic write_cfg(input cfg_addr_e addr, input logic [15:0] data);
    tick();
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
  endtask

  task automatic readback_all();
    int a;
    for (a = 0; a < buf_words; a++) begin
      if (written[a]) begin
        tick();
        rd_x = coord_w'(a);
        rd_y = coord_w'(a >> coord_w);
        @(posedge clk);
        @(negedge clk);
        check_value($sformatf("rd_data[x=%0d,y=%0d]", rd_x, rd_y), rd_data, model[a]);
      end
    end
  endtask

  task automatic run_one(input run_row_t row);
    int base;
    int done_before;
    int i;
    write_cfg(cfg_origin_x, 16'(row.org_x));
    write_cfg(cfg_origin_y, 16'(row.org_y));
    write_cfg(cfg_white_hold, row.white_hold);
    write_cfg(cfg_black_hold, row.black_hold);
    tick();
    cfg_we      = 1'b0;
    base        = wr_pos_q.size();
    done_before = done_count;
    tick();
    start       = 1'b1;
    started     = 1'b1;
    start_cycle = cycle_count;
    tick();
    start = 1'b0;
    check_value("busy", busy, 1'b1);
    if (row.restart) begin
      repeat (restart_wait) tick();
      check_value("busy", busy, 1'b1);
      start = 1'b1; // Must be ignored.
      tick();
      start = 1'b0;
    end
    while (done_count == done_before) tick();
    repeat (3) tick();
    check_value("done pulses", done_count - done_before, 1);
    check_value("busy", busy, 1'b0);
    check_value("write count", wr_pos_q.size() - base, 2 * pass_writes);
    check_value("first write delay", wr_cycle_q[base] - start_cycle, 2);
    for (i = 0; i < 2 * pass_writes; i++) begin
      check_value($sformatf("pix_wr pos #%0d", i), wr_pos_q[base + i],
                  outline_pos(row.org_x, row.org_y, i));
      check_value($sformatf("pix_wr.data #%0d", i), wr_data_q[base + i],
                  (i < pass_writes) ? colour_white : colour_black);
    end
    check_value("white hold kept",
                (wr_cycle_q[base + pass_writes] - wr_cycle_q[base + pass_writes - 1])
                >= row.white_hold, 1'b1);
    check_value("black hold kept",
                (done_cycle - wr_cycle_q[base + 2 * pass_writes - 1]) >= row.black_hold, 1'b1);
    readback_all();
  endtask

  initial begin
    int r;
    rst         = 1'b1;
    start       = 1'b0;
    cfg_we      = 1'b0;
    cfg_addr    = cfg_origin_x;
    cfg_wdata   = '0;
    rd_x        = '0;
    rd_y        = '0;
    started     = 1'b0;
    cycle_count = 0;
    done_count  = 0;
    done_cycle  = 0;
    start_cycle = 0;
    rng_state   = 32'd20364;
    for (r = 0; r < buf_words; r++) begin
      written[r] = 1'b0;
    end
    build_table();
    timeout_limit = reset_cycles;
    for (r = 0; r < n_runs; r++) begin
      timeout_limit += 2 * pass_cycles + runs[r].white_hold + runs[r].black_hold + row_slack;
    end
    repeat (reset_cycles) tick();
    rst = 1'b0;
    check_value("busy", busy, 1'b0);
    check_value("done", done, 1'b0);
    check_value("pix_wr.en", pix_wr.en, 1'b0);
    for (r = 0; r < n_runs; r++) begin
      run_one(runs[r]);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: design/cursor_palette_top.sv
`timescale 1ns/1ps

module cursor_palette_top
  import cursor_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               cfg_we,
  input  cfg_addr_e          cfg_addr,
  input  logic [15:0]        cfg_wdata,
  input  logic [coord_w-1:0] rd_x,
  input  logic [coord_w-1:0] rd_y,
  output logic               busy,
  output logic               done,
  output pix_wr_t            pix_wr,
  output logic [pix_w-1:0]   rd_data
);

  cursor_cfg_t        cfg;
  logic               load_origin;
  logic               step;
  logic               clear_steps;
  logic               side_done;
  dir_e               dir;
  logic               paint;
  logic [pix_w-1:0]   colour;
  logic               hold_start;
  logic               hold_sel;
  logic               hold_expired;
  logic [coord_w-1:0] cur_x;
  logic [coord_w-1:0] cur_y;

  cursor_cfg_regs cursor_cfg_regs_inst (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  cursor_outline_fsm cursor_outline_fsm_inst (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .side_done    (side_done),
    .hold_expired (hold_expired),
    .load_origin  (load_origin),
    .step         (step),
    .clear_steps  (clear_steps),
    .paint        (paint),
    .hold_start   (hold_start),
    .hold_sel     (hold_sel),
    .busy         (busy),
    .done         (done),
    .dir          (dir),
    .colour       (colour)
  );

  cursor_position cursor_position_inst (
    .clk         (clk),
    .rst         (rst),
    .load_origin (load_origin),
    .step        (step),
    .clear_steps (clear_steps),
    .dir         (dir),
    .cfg         (cfg),
    .cur_x       (cur_x),
    .cur_y       (cur_y),
    .side_done   (side_done)
  );

  blink_timer blink_timer_inst (
    .clk          (clk),
    .rst          (rst),
    .hold_start   (hold_start),
    .hold_sel     (hold_sel),
    .cfg          (cfg),
    .hold_expired (hold_expired)
  );

  // Paint strobe and current position form the write.
  assign pix_wr = '{en: paint, x: cur_x, y: cur_y, data: colour};

  pixel_buffer pixel_buffer_inst (
    .clk     (clk),
    .pix_wr  (pix_wr),
    .rd_x    (rd_x),
    .rd_y    (rd_y),
    .rd_data (rd_data)
  );

endmodule

// File: design/pixel_buffer.sv
`timescale 1ns/1ps

module pixel_buffer
  import cursor_pkg::*;
(
  input  logic               clk,
  input  pix_wr_t            pix_wr,
  input  logic [coord_w-1:0] rd_x,
  input  logic [coord_w-1:0] rd_y,
  output logic [pix_w-1:0]   rd_data
);

  logic [pix_w-1:0]     mem [buf_words];
  logic [2*coord_w-1:0] wr_addr;
  logic [2*coord_w-1:0] rd_addr;

  // Row major, y selects the row.
  assign wr_addr = {pix_wr.y, pix_wr.x};
  assign rd_addr = {rd_y, rd_x};

  always_ff @(posedge clk) begin
    if (pix_wr.en) begin
      mem[wr_addr] <= pix_wr.data;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr]; // One cycle read latency.
  end

endmodule

// File: design/blink_timer.sv
`timescale 1ns/1ps

module blink_timer
  import cursor_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        hold_start,
  input  logic        hold_sel,
  input  cursor_cfg_t cfg,
  output logic        hold_expired
);

  logic [hold_w-1:0] count_q;
  logic [hold_w-1:0] load_val;

  // 0 picks the white hold, 1 the black one.
  assign load_val = hold_sel ? cfg.black_hold : cfg.white_hold;

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (hold_start) begin
      count_q <= load_val;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Stale zero from the previous hold must not count while a load is pending.
  assign hold_expired = (count_q == '0) && !hold_start;

endmodule

// File: design/cursor_position.sv
`timescale 1ns/1ps

module cursor_position
  import cursor_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               load_origin,
  input  logic               step,
  input  logic               clear_steps,
  input  dir_e               dir,
  input  cursor_cfg_t        cfg,
  output logic [coord_w-1:0] cur_x,
  output logic [coord_w-1:0] cur_y,
  output logic               side_done
);

  logic [coord_w-1:0] x_q;
  logic [coord_w-1:0] y_q;
  logic [step_w-1:0]  steps_q;
  logic               at_edge;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_q <= '0;
      y_q <= '0;
    end else if (load_origin) begin
      x_q <= cfg.org_x;
      y_q <= cfg.org_y;
    end else if (step) begin
      case (dir)
        dir_right: x_q <= x_q + 1'b1;
        dir_down:  y_q <= y_q + 1'b1;
        dir_left:  x_q <= x_q - 1'b1;
        default:   y_q <= y_q - 1'b1;
      endcase
    end
  end

  // Steps taken on the current side.
  always_ff @(posedge clk) begin
    if (rst || load_origin || clear_steps) begin
      steps_q <= '0;
    end else if (step) begin
      steps_q <= steps_q + 1'b1;
    end
  end

  // Counts the step in flight, so the FSM leaves the side right after it.
  assign side_done = step && (steps_q == step_w'(side_len - 1));

  assign cur_x = x_q;
  assign cur_y = y_q;

  always_comb begin
    case (dir)
      dir_right: at_edge = (x_q == coord_w'(buf_dim - 1));
      dir_down:  at_edge = (y_q == coord_w'(buf_dim - 1));
      dir_left:  at_edge = (x_q == '0);
      default:   at_edge = (y_q == '0);
    endcase
  end

  // Origin must leave room for a full side in every direction.
  in_buffer_a : assert property (
    @(posedge clk) disable iff (rst) step |-> !at_edge
  ) else $error("cursor_position: step would wrap out of the buffer");

endmodule

// File: design/cursor_outline_fsm.sv
`timescale 1ns/1ps

module cursor_outline_fsm
  import cursor_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic             side_done,
  input  logic             hold_expired,
  output logic             load_origin,
  output logic             step,
  output logic             clear_steps,
  output logic             paint,
  output logic             hold_start,
  output logic             hold_sel,
  output logic             busy,
  output logic             done,
  output dir_e             dir,
  output logic [pix_w-1:0] colour
);

  paint_state_e     state_q;
  paint_state_e     state_d;
  dir_e             dir_q;
  dir_e             dir_d;
  logic [pix_w-1:0] colour_q;
  logic [pix_w-1:0] colour_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= st_idle;
      dir_q    <= dir_right;
      colour_q <= colour_white;
    end else begin
      state_q  <= state_d;
      dir_q    <= dir_d;
      colour_q <= colour_d;
    end
  end

  always_comb begin
    state_d  = state_q;
    dir_d    = dir_q;
    colour_d = colour_q;
    case (state_q)
      st_idle: begin
        if (start) begin
          state_d = st_load;
        end
      end
      st_load: begin
        dir_d    = dir_right;
        colour_d = colour_white; // First pass is always white.
        state_d  = st_paint_r;
      end
      st_paint_r: state_d = st_adv_r;
      st_adv_r:   state_d = side_done ? st_side : st_paint_r;
      st_paint_d: state_d = st_adv_d;
      st_adv_d:   state_d = side_done ? st_side : st_paint_d;
      st_paint_l: state_d = st_adv_l;
      st_adv_l:   state_d = side_done ? st_side : st_paint_l;
      st_paint_u: state_d = st_adv_u;
      st_adv_u:   state_d = side_done ? st_side : st_paint_u;
      st_side: begin
        case (dir_q)
          dir_right: begin
            dir_d   = dir_down;
            state_d = st_paint_d;
          end
          dir_down: begin
            dir_d   = dir_left;
            state_d = st_paint_l;
          end
          dir_left: begin
            dir_d   = dir_up;
            state_d = st_paint_u;
          end
          default: begin
            // Outline closed, back at the origin.
            dir_d   = dir_right;
            state_d = (colour_q == colour_white) ? st_white_hold : st_black_hold;
          end
        endcase
      end
      st_white_hold: begin
        if (hold_expired) begin
          state_d = st_colour;
        end
      end
      st_colour: begin
        colour_d = colour_black;
        state_d  = st_paint_r;
      end
      st_black_hold: begin
        if (hold_expired) begin
          state_d = st_done;
        end
      end
      st_done: state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_comb begin
    load_origin = (state_q == st_load);
    paint       = (state_q == st_paint_r) || (state_q == st_paint_d) ||
                  (state_q == st_paint_l) || (state_q == st_paint_u);
    step        = (state_q == st_adv_r) || (state_q == st_adv_d) ||
                  (state_q == st_adv_l) || (state_q == st_adv_u);
    clear_steps = (state_q == st_side);
    hold_start  = (state_q == st_side) && (dir_q == dir_up); // Timer loads here.
    hold_sel    = (colour_q == colour_black);
    busy        = (state_q != st_idle);
    done        = (state_q == st_done);
  end

  assign dir    = dir_q;
  assign colour = colour_q;

  paint_hold_excl_a : assert property (
    @(posedge clk) disable iff (rst) !(paint && hold_start)
  ) else $error("cursor_outline_fsm: paint during hold start");

  done_pulse_a : assert property (
    @(posedge clk) disable iff (rst) done |=> !done
  ) else $error("cursor_outline_fsm: done held longer than one cycle");

endmodule

// File: design/cursor_cfg_regs.sv
`timescale 1ns/1ps

module cursor_cfg_regs
  import cursor_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cfg_we,
  input  cfg_addr_e   cfg_addr,
  input  logic [15:0] cfg_wdata,
  output cursor_cfg_t cfg
);

  cursor_cfg_t cfg_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_q.org_x      <= '0;
      cfg_q.org_y      <= '0;
      cfg_q.white_hold <= hold_w'(1);
      cfg_q.black_hold <= hold_w'(1);
    end else if (cfg_we) begin
      case (cfg_addr)
        cfg_origin_x: begin
          cfg_q.org_x <= cfg_wdata[coord_w-1:0]; // Upper bits are dropped.
        end
        cfg_origin_y: begin
          cfg_q.org_y <= cfg_wdata[coord_w-1:0];
        end
        cfg_white_hold: begin
          cfg_q.white_hold <= cfg_wdata[hold_w-1:0];
        end
        cfg_black_hold: begin
          cfg_q.black_hold <= cfg_wdata[hold_w-1:0];
        end
        default: begin
          cfg_q <= cfg_q;
        end
      endcase
    end
  end

  assign cfg = cfg_q;

  // A zero hold would make the timer expire before the FSM waits on it.
  hold_nonzero_a : assert property (
    @(posedge clk) disable iff (rst)
    (cfg_q.white_hold != '0) && (cfg_q.black_hold != '0)
  ) else $error("cursor_cfg_regs: hold time programmed to zero");

endmodule

// File: design/cursor_pkg.sv
package cursor_pkg;

  // Frame buffer geometry.
  localparam int buf_dim   = 16;
  localparam int buf_words = buf_dim * buf_dim;
  localparam int coord_w   = 4;
  localparam int pix_w     = 8;

  // Outline geometry.
  localparam int side_len = 4;
  localparam int step_w   = $clog2(side_len + 1);

  localparam logic [pix_w-1:0] colour_white = 8'hFF;
  localparam logic [pix_w-1:0] colour_black = 8'h00;

  localparam int hold_w = 16;

  typedef enum logic [1:0] {
    cfg_origin_x   = 2'd0,
    cfg_origin_y   = 2'd1,
    cfg_white_hold = 2'd2,
    cfg_black_hold = 2'd3
  } cfg_addr_e;

  typedef struct packed {
    logic [coord_w-1:0] org_x;
    logic [coord_w-1:0] org_y;
    logic [hold_w-1:0]  white_hold;
    logic [hold_w-1:0]  black_hold;
  } cursor_cfg_t;

  typedef struct packed {
    logic               en;
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    logic [pix_w-1:0]   data;
  } pix_wr_t;

  typedef enum logic [1:0] {
    dir_right = 2'd0,
    dir_down  = 2'd1,
    dir_left  = 2'd2,
    dir_up    = 2'd3
  } dir_e;

  typedef enum logic [3:0] {
    st_idle,
    st_load,
    st_paint_r,
    st_adv_r,
    st_paint_d,
    st_adv_d,
    st_paint_l,
    st_adv_l,
    st_paint_u,
    st_adv_u,
    st_side,
    st_white_hold,
    st_colour,
    st_black_hold,
    st_done
  } paint_state_e;

endpackage
